//--- heapPkg.sv
// Shared sizes, opcodes and error codes for the array heap
// Storage sizes are fixed here; the widths must stay consistent with the counts
package heapPkg;

  // --------------------
  // Sizes and widths
  // --------------------
  localparam int ArrayBits   = 2;                 // Bits in an array number
  localparam int ArrayCount  = 4;                 // Arrays in the heap
  localparam int IndexBits   = 3;                 // Bits in an element index
  localparam int ArrayLength = 8;                 // Elements per array
  localparam int SizeBits    = IndexBits + 1;     // Size can reach ArrayLength
  localparam int DataBits    = 12;                // Element width
  localparam int OpBits      = 4;                 // Opcode width

  // --------------------
  // Opcodes
  // --------------------
  localparam logic [OpBits-1:0] OpClear    = 4'd0;   // Forget all arrays
  localparam logic [OpBits-1:0] OpAlloc    = 4'd1;   // Hand out an array
  localparam logic [OpBits-1:0] OpFree     = 4'd2;   // Return an array
  localparam logic [OpBits-1:0] OpWrite    = 4'd3;   // Store one element
  localparam logic [OpBits-1:0] OpRead     = 4'd4;   // Fetch one element
  localparam logic [OpBits-1:0] OpSize     = 4'd5;   // Current size
  localparam logic [OpBits-1:0] OpPush     = 4'd6;   // Append at the end
  localparam logic [OpBits-1:0] OpPop      = 4'd7;   // Remove from the end
  localparam logic [OpBits-1:0] OpIndex    = 4'd8;   // Last match, one based
  localparam logic [OpBits-1:0] OpLess     = 4'd9;   // Count smaller
  localparam logic [OpBits-1:0] OpGreater  = 4'd10;  // Count larger
  localparam logic [OpBits-1:0] OpAdd      = 4'd11;  // Add, return new value
  localparam logic [OpBits-1:0] OpSubtract = 4'd12;  // Subtract, return new value

  // --------------------
  // Error codes
  // --------------------
  localparam int ErrBits = 3;
  localparam logic [ErrBits-1:0] ErrNone         = 3'd0;
  localparam logic [ErrBits-1:0] ErrNotAllocated = 3'd1;  // Never handed out
  localparam logic [ErrBits-1:0] ErrFreed        = 3'd2;  // Handed out, then freed
  localparam logic [ErrBits-1:0] ErrBounds       = 3'd3;  // Index not below size
  localparam logic [ErrBits-1:0] ErrFull         = 3'd4;  // Push on full array
  localparam logic [ErrBits-1:0] ErrEmpty        = 3'd5;  // Pop on empty array
  localparam logic [ErrBits-1:0] ErrNoArrays     = 3'd6;  // Nothing left to hand out

endpackage

//--- heapAllocator.sv
// Hands out array numbers; freed arrays are reused last in, first out
// The caller must only free an allocated array and only alloc when canAlloc is high
`timescale 1ns/10ps

module heapAllocator (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          clear,          // Forget every array
  input  logic                          alloc,          // Commit nextArray
  input  logic                          free,           // Return array
  input  logic [heapPkg::ArrayBits-1:0] array,          // Array being checked or freed
  output logic                          allocated,      // Array currently in use
  output logic                          everAllocated,  // Array handed out at some point
  output logic [heapPkg::ArrayBits-1:0] nextArray,      // What alloc would return
  output logic                          canAlloc        // Some array is available
);
  import heapPkg::*;

  logic [ArrayBits-1:0] freedStack [ArrayCount];  // Freed array numbers
  logic [ArrayBits:0]   stackTop;                 // Entries on the freed stack
  logic [ArrayBits:0]   handedOut;                // Fresh arrays given so far
  logic [ArrayCount-1:0] allocFlags;              // One flag per array
  logic [ArrayBits-1:0] topIndex;                 // Slot of the newest freed entry
  logic                 stackEmpty;

  // --------------------
  // Lookups
  // --------------------
  assign topIndex      = stackTop[ArrayBits-1:0] - ArrayBits'(1);  // Wraps right when full
  assign stackEmpty    = (stackTop == '0);
  assign allocated     = allocFlags[array];
  assign everAllocated = ({1'b0, array} < handedOut);
  assign canAlloc      = !stackEmpty || (handedOut != (ArrayBits + 1)'(ArrayCount));
  assign nextArray     = stackEmpty ? handedOut[ArrayBits-1:0]  // Fresh array
                                    : freedStack[topIndex];     // Reuse newest freed

  // --------------------
  // Bookkeeping
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop   <= '0;
      handedOut  <= '0;
      allocFlags <= '0;
    end else if (clear) begin                   // Same as reset
      stackTop   <= '0;
      handedOut  <= '0;
      allocFlags <= '0;
    end else if (alloc) begin
      if (!stackEmpty) begin
        stackTop <= stackTop - (ArrayBits + 1)'(1);    // Pop freed entry
      end else begin
        handedOut <= handedOut + (ArrayBits + 1)'(1);  // Take a fresh one
      end
      allocFlags[nextArray] <= 1'b1;
    end else if (free) begin
      stackTop          <= stackTop + (ArrayBits + 1)'(1);
      allocFlags[array] <= 1'b0;
    end
  end

  // Stack contents only matter below stackTop
  always_ff @(posedge clock) begin
    if (free && !clear) begin
      freedStack[stackTop[ArrayBits-1:0]] <= array;
    end
  end

endmodule

//--- arrayStore.sv
// Element rows and sizes of every array
// Rows are read whole and combinationally; one element and one size written per clock
// Element contents are undefined until written; only sizes are reset
`timescale 1ns/10ps

module arrayStore (
  input  logic                                              clock,
  input  logic                                              resetN,
  input  logic [heapPkg::ArrayBits-1:0]                     array,         // Row selected
  input  logic                                              writeElement,  // Store one element
  input  logic [heapPkg::IndexBits-1:0]                     elementIndex,
  input  logic [heapPkg::DataBits-1:0]                      elementValue,
  input  logic                                              writeSize,     // Update the size
  input  logic [heapPkg::SizeBits-1:0]                      newSize,
  output logic [heapPkg::ArrayLength*heapPkg::DataBits-1:0] row,           // Element 0 lowest
  output logic [heapPkg::SizeBits-1:0]                      size
);
  import heapPkg::*;

  logic [DataBits-1:0] elements [ArrayCount][ArrayLength];  // Element storage
  logic [SizeBits-1:0] sizes    [ArrayCount];               // Used length per array

  // --------------------
  // Read side
  // --------------------
  always_comb begin
    for (int i = 0; i < ArrayLength; i++) begin
      row[i*DataBits +: DataBits] = elements[array][i];   // Flatten the row
    end
  end

  assign size = sizes[array];

  // --------------------
  // Write side
  // --------------------
  always_ff @(posedge clock) begin
    if (writeElement) begin
      elements[array][elementIndex] <= elementValue;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < ArrayCount; a++) begin
        sizes[a] <= '0;                                   // All arrays empty
      end
    end else if (writeSize) begin
      sizes[array] <= newSize;
    end
  end

endmodule

//--- elementOps.sv
// Result and updates of one element operation on one row, purely combinational
// Access checks on the array itself are done by the caller
// Unknown opcodes give a zero result and no updates
`timescale 1ns/10ps

module elementOps (
  input  logic [heapPkg::OpBits-1:0]                        op,
  input  logic [heapPkg::ArrayLength*heapPkg::DataBits-1:0] row,           // Element 0 lowest
  input  logic [heapPkg::SizeBits-1:0]                      size,
  input  logic [heapPkg::IndexBits-1:0]                     index,
  input  logic [heapPkg::DataBits-1:0]                      data,
  output logic [heapPkg::DataBits-1:0]                      result,
  output logic                                              writeElement,
  output logic [heapPkg::IndexBits-1:0]                     elementIndex,
  output logic [heapPkg::DataBits-1:0]                      elementValue,
  output logic                                              writeSize,
  output logic [heapPkg::SizeBits-1:0]                      newSize,
  output logic [heapPkg::ErrBits-1:0]                       opError
);
  import heapPkg::*;

  logic [DataBits-1:0]  elements [ArrayLength];  // Unpacked row
  logic [SizeBits-1:0]  matchPos;                // Last match plus one
  logic [SizeBits-1:0]  lessCount;
  logic [SizeBits-1:0]  greaterCount;
  logic [IndexBits-1:0] lastIndex;               // Top element for Pop
  logic                 inBounds;                // index below size
  logic [DataBits-1:0]  sum;
  logic [DataBits-1:0]  difference;

  assign lastIndex  = size[IndexBits-1:0] - IndexBits'(1);  // Full array wraps to 7
  assign inBounds   = ({1'b0, index} < size);
  assign sum        = elements[index] + data;               // Wraps at DataBits
  assign difference = elements[index] - data;

  // --------------------
  // Search over the used part
  // --------------------
  always_comb begin
    matchPos     = '0;
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < ArrayLength; i++) begin
      elements[i] = row[i*DataBits +: DataBits];
      if (SizeBits'(i) < size) begin
        if (elements[i] == data) matchPos = SizeBits'(i + 1);     // Later match wins
        if (elements[i] < data) lessCount = lessCount + SizeBits'(1);
        if (elements[i] > data) greaterCount = greaterCount + SizeBits'(1);
      end
    end
  end

  // --------------------
  // Per opcode
  // --------------------
  always_comb begin
    result       = '0;
    writeElement = 1'b0;
    elementIndex = index;
    elementValue = data;
    writeSize    = 1'b0;
    newSize      = size;
    opError      = ErrNone;
    case (op)
      OpWrite: begin
        result       = data;                              // Echo
        writeElement = 1'b1;
        if (!inBounds) begin
          writeSize = 1'b1;                               // Grow to cover index
          newSize   = {1'b0, index} + SizeBits'(1);
        end
      end
      OpRead: begin
        if (inBounds) result = elements[index];
        else opError = ErrBounds;
      end
      OpPush: begin
        if (size == SizeBits'(ArrayLength)) begin
          opError = ErrFull;
        end else begin
          result       = data;
          writeElement = 1'b1;
          elementIndex = size[IndexBits-1:0];             // First free slot
          writeSize    = 1'b1;
          newSize      = size + SizeBits'(1);
        end
      end
      OpPop: begin
        if (size == '0) begin
          opError = ErrEmpty;
        end else begin
          result    = elements[lastIndex];
          writeSize = 1'b1;
          newSize   = size - SizeBits'(1);
        end
      end
      OpIndex:   result = DataBits'(matchPos);
      OpLess:    result = DataBits'(lessCount);
      OpGreater: result = DataBits'(greaterCount);
      OpAdd, OpSubtract: begin
        if (inBounds) begin
          result       = (op == OpAdd) ? sum : difference;  // New value
          writeElement = 1'b1;
          elementValue = (op == OpAdd) ? sum : difference;
        end else begin
          opError = ErrBounds;
        end
      end
      default: ;                                          // Handled by the top level
    endcase
  end

endmodule

//--- arrayHeap.sv
// Heap of fixed-size arrays, one operation in flight
// Response is registered one clock after acceptance and held until taken
// A new request is accepted only when the response slot is free or being taken
`timescale 1ns/10ps

module arrayHeap (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          reqValid,
  output logic                          reqReady,
  input  logic [heapPkg::OpBits-1:0]    reqOp,
  input  logic [heapPkg::ArrayBits-1:0] reqArray,
  input  logic [heapPkg::IndexBits-1:0] reqIndex,
  input  logic [heapPkg::DataBits-1:0]  reqData,
  output logic                          respValid,
  input  logic                          respReady,
  output logic [heapPkg::DataBits-1:0]  respData,
  output logic [heapPkg::ErrBits-1:0]   respError
);
  import heapPkg::*;

  logic                             accept;         // Request transfer this clock
  logic                             commit;         // Accepted with no error
  logic                             isClear;
  logic                             isAlloc;
  logic                             isFree;
  logic                             allocated;
  logic                             everAllocated;
  logic [ArrayBits-1:0]             nextArray;
  logic                             canAlloc;
  logic [ArrayBits-1:0]             storeArray;     // Row being read or written
  logic [ArrayLength*DataBits-1:0]  row;
  logic [SizeBits-1:0]              size;
  logic [DataBits-1:0]              opResult;
  logic                             opWriteElement;
  logic [IndexBits-1:0]             elementIndex;
  logic [DataBits-1:0]              elementValue;
  logic                             opWriteSize;
  logic [SizeBits-1:0]              opNewSize;
  logic [ErrBits-1:0]               opError;
  logic [ErrBits-1:0]               reqError;       // Combined error for this request
  logic [DataBits-1:0]              reqResult;

  // --------------------
  // Handshake and decode
  // --------------------
  assign reqReady   = !respValid || respReady;
  assign accept     = reqValid && reqReady;
  assign isClear    = (reqOp == OpClear);
  assign isAlloc    = (reqOp == OpAlloc);
  assign isFree     = (reqOp == OpFree);
  assign commit     = accept && (reqError == ErrNone);
  assign storeArray = isAlloc ? nextArray : reqArray;      // Alloc touches the new array

  always_comb begin
    reqError = ErrNone;
    if (isAlloc) begin
      if (!canAlloc) reqError = ErrNoArrays;
    end else if (!isClear) begin
      if (!everAllocated) reqError = ErrNotAllocated;      // Checked before freed
      else if (!allocated) reqError = ErrFreed;
      else reqError = opError;
    end
  end

  always_comb begin
    if (reqError != ErrNone) reqResult = '0;
    else if (isAlloc) reqResult = DataBits'(nextArray);
    else if (reqOp == OpSize) reqResult = DataBits'(size);
    else if (isClear || isFree) reqResult = '0;
    else reqResult = opResult;
  end

  // --------------------
  // Response register
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
    end else if (accept) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;                                   // Taken
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      respData  <= reqResult;
      respError <= reqError;
    end
  end

  // --------------------
  // Instances
  // --------------------
  heapAllocator i_heapAllocator (
    .clock        (clock),
    .resetN       (resetN),
    .clear        (accept && isClear),
    .alloc        (commit && isAlloc),
    .free         (commit && isFree),
    .array        (reqArray),
    .allocated    (allocated),
    .everAllocated(everAllocated),
    .nextArray    (nextArray),
    .canAlloc     (canAlloc)
  );

  arrayStore i_arrayStore (
    .clock       (clock),
    .resetN      (resetN),
    .array       (storeArray),
    .writeElement(commit && opWriteElement),
    .elementIndex(elementIndex),
    .elementValue(elementValue),
    .writeSize   (commit && (opWriteSize || isAlloc)),
    .newSize     (isAlloc ? SizeBits'(0) : opNewSize),     // New array starts empty
    .row         (row),
    .size        (size)
  );

  elementOps i_elementOps (
    .op          (reqOp),
    .row         (row),
    .size        (size),
    .index       (reqIndex),
    .data        (reqData),
    .result      (opResult),
    .writeElement(opWriteElement),
    .elementIndex(elementIndex),
    .elementValue(elementValue),
    .writeSize   (opWriteSize),
    .newSize     (opNewSize),
    .opError     (opError)
  );

endmodule

//--- arrayHeap_properties.sv
// Handshake checks for the array heap, bound into arrayHeap
// Only the response side is checked; request payload is not inspected
`timescale 1ns/10ps

module arrayHeapProperties (
  input logic                         clock,
  input logic                         resetN,
  input logic                         reqReady,
  input logic                         respValid,
  input logic                         respReady,
  input logic [heapPkg::DataBits-1:0] respData,
  input logic [heapPkg::ErrBits-1:0]  respError
);

  // --------------------
  // Reset
  // --------------------
  respIdleInReset: assert property (@(posedge clock) !resetN |-> !respValid)
    else $error("respValid high while reset is asserted");

  // --------------------
  // Back-pressure
  // --------------------
  respHeld: assert property (@(posedge clock) disable iff (!resetN)
    respValid && !respReady |=> respValid && $stable(respData) && $stable(respError))
    else $error("Response changed or dropped before it was taken");

  readyLowWhenHeld: assert property (@(posedge clock) disable iff (!resetN)
    respValid && !respReady |-> !reqReady)
    else $error("reqReady high while a response is held back");

endmodule

//--- arrayHeap_tb.sv
// Testbench for arrayHeap; requests and expected responses come from heap_stim.txt
// The list runs twice, first with respReady always high, then with random back-pressure
// Must run from the project root so the stim file is found
`timescale 1ns/10ps

module arrayHeap_tb;
  import heapPkg::*;

  localparam int          Timeout     = 40;         // Cycles per wait
  localparam int          RecordWords = 6;          // Words per stim line
  localparam int          MaxRecords  = 80;
  localparam int unsigned Seed        = 32'hd2ae0ce8;
  localparam logic [DataBits-1:0] EndMarker = DataBits'('hf);  // Opcode f ends the list

  logic                 clock = 1'b0;
  logic                 resetN;
  logic                 reqValid;
  logic                 reqReady;
  logic [OpBits-1:0]    reqOp;
  logic [ArrayBits-1:0] reqArray;
  logic [IndexBits-1:0] reqIndex;
  logic [DataBits-1:0]  reqData;
  logic                 respValid;
  logic                 respReady = 1'b0;
  logic [DataBits-1:0]  respData;
  logic [ErrBits-1:0]   respError;
  logic                 randomReady = 1'b0;  // Back-pressure on or off
  logic [DataBits-1:0]  stim [MaxRecords*RecordWords];
  int                   valueErrors   = 0;
  int                   timeoutErrors = 0;
  int                   latencyErrors = 0;
  int                   takeCount     = 0;   // Responses taken by the client

  always #5 clock = ~clock;  // 10 ns period

  // --------------------
  // Client side of the response
  // --------------------
  always @(posedge clock) begin
    if (randomReady) respReady <= ($urandom % 3) != 0;  // Stall about a third of cycles
    else respReady <= 1'b1;
  end

  always @(posedge clock) begin
    if (resetN && respValid && respReady) takeCount <= takeCount + 1;
  end

  arrayHeap i_arrayHeap (
    .clock    (clock),
    .resetN   (resetN),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .reqOp    (reqOp),
    .reqArray (reqArray),
    .reqIndex (reqIndex),
    .reqData  (reqData),
    .respValid(respValid),
    .respReady(respReady),
    .respData (respData),
    .respError(respError)
  );

  bind arrayHeap arrayHeapProperties i_arrayHeapProperties (
    .clock(clock), .resetN(resetN), .reqReady(reqReady),
    .respValid(respValid), .respReady(respReady), .respData(respData), .respError(respError)
  );

  task automatic checkData(input string name, input logic [DataBits-1:0] actual,
                           input logic [DataBits-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
      valueErrors++;
    end
  endtask

  task automatic checkError(input string name, input logic [ErrBits-1:0] actual,
                            input logic [ErrBits-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %0d, expected %0d", $time, name, actual, expected);
      valueErrors++;
    end
  endtask

  // Called at a rising edge; returns at the edge where the response is taken
  task automatic runRequest(input int record, output bit ok);
    int                  base;
    int                  waited;
    logic [DataBits-1:0] expData;
    logic [ErrBits-1:0]  expError;
    base     = record * RecordWords;
    ok       = 1'b0;
    expData  = stim[base+4];
    expError = ErrBits'(stim[base+5]);
    reqValid <= 1'b1;
    reqOp    <= OpBits'(stim[base]);
    reqArray <= ArrayBits'(stim[base+1]);
    reqIndex <= IndexBits'(stim[base+2]);
    reqData  <= stim[base+3];
    waited = 0;
    @(negedge clock);                                // Handshake inputs settled here
    while (!reqReady && waited < Timeout) begin
      @(negedge clock);
      waited++;
    end
    if (reqReady) begin
      @(posedge clock);                              // Accepted
      reqValid <= 1'b0;
      waited = 0;
      @(negedge clock);
      if (!respValid) begin                          // Response due one clock after accept
        $display("Response to record %0d not valid one cycle after acceptance", record);
        latencyErrors++;
      end
      while (!(respValid && respReady) && waited < Timeout) begin
        @(negedge clock);
        waited++;
      end
      if (respValid && respReady) begin
        checkData($sformatf("respData (record %0d)", record), respData, expData);
        checkError($sformatf("respError (record %0d)", record), respError, expError);
        @(posedge clock);                            // Taken
        ok = 1'b1;
      end else begin
        $display("Timeout: no response to record %0d", record);
        timeoutErrors++;
      end
    end else begin
      $display("Timeout: record %0d was never accepted", record);
      timeoutErrors++;
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    bit ok;
    int record;
    int sent;
    int countErrors;
    void'($urandom(Seed));
    resetN   = 1'b0;
    reqValid = 1'b0;
    reqOp    = '0;
    reqArray = '0;
    reqIndex = '0;
    reqData  = '0;
    ok          = 1'b1;
    sent        = 0;
    countErrors = 0;
    $readmemh("heap_stim.txt", stim);
    repeat (10) @(posedge clock);
    resetN <= 1'b1;
    for (int pass = 0; pass < 2 && ok; pass++) begin
      randomReady <= (pass == 1);
      @(posedge clock);
      record = 0;
      while (ok && record < MaxRecords && stim[record*RecordWords] !== EndMarker) begin
        runRequest(record, ok);
        if (ok) sent++;
        record++;
      end
    end
    repeat (4) @(posedge clock);                     // Catch any stray response
    if (takeCount != sent) begin
      $display("Client took %0d responses for %0d requests", takeCount, sent);
      countErrors++;
    end
    $display("Errors: %0d value, %0d timeout, %0d latency, %0d count", valueErrors,
             timeoutErrors, latencyErrors, countErrors);
    if (valueErrors == 0 && timeoutErrors == 0 && latencyErrors == 0 && countErrors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- heap_stim.txt
// op array index data expectedData expectedError, all hex
// Opcode f ends the list; every pass starts with Clear
0 0 0 000 000 0
4 0 0 000 000 1
1 0 0 000 000 0
1 0 0 000 001 0
1 0 0 000 002 0
1 0 0 000 003 0
1 0 0 000 000 6
2 1 0 000 000 0
4 1 0 000 000 2
1 0 0 000 001 0
// Write, Size, Read on array 0
3 0 0 00a 00a 0
3 0 1 014 014 0
3 0 2 01e 01e 0
5 0 0 000 003 0
4 0 3 000 000 3
4 0 1 000 014 0
// Index, Less, Greater on 10 20 30
8 0 0 01e 003 0
8 0 0 014 002 0
8 0 0 00a 001 0
8 0 0 00f 000 0
9 0 0 023 003 0
9 0 0 019 002 0
9 0 0 00f 001 0
9 0 0 005 000 0
a 0 0 023 000 0
a 0 0 019 001 0
a 0 0 00f 002 0
a 0 0 005 003 0
// Push to full, then Pop to empty on array 2
6 2 0 101 101 0
6 2 0 102 102 0
6 2 0 103 103 0
6 2 0 104 104 0
6 2 0 105 105 0
6 2 0 106 106 0
6 2 0 107 107 0
6 2 0 108 108 0
6 2 0 109 000 4
5 2 0 000 008 0
7 2 0 000 108 0
7 2 0 000 107 0
7 2 0 000 106 0
7 2 0 000 105 0
7 2 0 000 104 0
7 2 0 000 103 0
7 2 0 000 102 0
7 2 0 000 101 0
7 2 0 000 000 5
// Add and Subtract with wrap on array 0
b 0 1 005 019 0
4 0 1 000 019 0
c 0 0 00b fff 0
4 0 0 000 fff 0
b 0 2 ff0 00e 0
4 0 2 000 00e 0
b 0 3 001 000 3
f 0 0 000 000 0

//--- tb.f
heapPkg.sv
heapAllocator.sv
arrayStore.sv
elementOps.sv
arrayHeap.sv
arrayHeap_properties.sv
arrayHeap_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = arrayHeap_tb
FILELIST = tb.f
LOG      = sim.log
PASSTEXT = PASS: all tests

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qxF "$(PASSTEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
